// ==== hw/mem_subsys_config.svh ====
//######################################
// Memory subsystem parameters
//######################################

`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Bus widths
`define MEM_ADDR_W 32 // Byte address
`define MEM_DATA_W 32

// RAM geometry and timing
`define MEM_WORDS 256
`define MEM_WAIT 2 // Wait states before ready

`endif

// ==== hw/mem_bus_pkg.sv ====
//######################################
// Memory bus datapath types
//######################################

`include "mem_subsys_config.svh"

package mem_bus_pkg;

	// Byte address as seen on every port
	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

	typedef logic [`MEM_DATA_W-1:0] mem_data_t;

	// Word index into the RAM, address bits above the byte offset
	typedef logic [$clog2(`MEM_WORDS)-1:0] mem_index_t;

endpackage

// ==== hw/arb_pkg.sv ====
//######################################
// Arbitration types
//######################################

`include "mem_subsys_config.svh"

package arb_pkg;

	typedef enum logic [1:0] {
		ARB_IDLE    = 2'd0, // Bus free, sampling requests
		ARB_SERVE_A = 2'd1,
		ARB_SERVE_B = 2'd2,
		ARB_SERVE_C = 2'd3
	} arb_state_e;

	// Which port currently owns the bus
	typedef enum logic [1:0] {
		GRANT_NONE = 2'd0,
		GRANT_A    = 2'd1,
		GRANT_B    = 2'd2,
		GRANT_C    = 2'd3
	} grant_e;

endpackage

// ==== hw/mem_bus_if.sv ====
//######################################
// Request/ready memory bus
//######################################

`timescale 1ns/100ps

interface mem_bus_if import mem_bus_pkg::*; ();

	logic      request; // Held until ready
	logic      rw;      // 1 = write
	mem_addr_t address;
	mem_data_t wdata;
	logic      ready;   // One-cycle pulse
	mem_data_t rdata;   // Valid with ready on reads

	modport initiator (
		output request, rw, address, wdata,
		input  ready, rdata
	);

	modport target (
		input  request, rw, address, wdata,
		output ready, rdata
	);

	// Observation only
	modport monitor (
		input request, rw, address, wdata, ready, rdata
	);

endinterface

// ==== hw/port_arbiter.sv ====
//######################################
// Fixed-priority bus arbiter
//######################################

`timescale 1ns/100ps

module port_arbiter import arb_pkg::*; (
	input  logic       i_clock,
	input  logic       i_rst_n,
	input  logic [2:0] i_port_request, // A in bit 0, highest priority
	input  logic       i_bus_ready,
	output grant_e     o_grant,
	output logic       o_bus_request
);

	arb_state_e state;
	arb_state_e next_state;
	grant_e     next_grant;

	// Next state
	always_comb begin
		next_state = state;

		case (state)
			// Only pick a new owner while the bus is free
			ARB_IDLE: begin
				if (i_port_request[0]) begin
					next_state = ARB_SERVE_A;
				end else if (i_port_request[1]) begin
					next_state = ARB_SERVE_B;
				end else if (i_port_request[2]) begin
					next_state = ARB_SERVE_C;
				end
			end

			// Hold the owner until the RAM answers
			ARB_SERVE_A,
			ARB_SERVE_B,
			ARB_SERVE_C: begin
				if (i_bus_ready) begin
					next_state = ARB_IDLE;
				end
			end

			default: next_state = ARB_IDLE;
		endcase
	end

	// Grant that goes with the next state
	always_comb begin
		case (next_state)
			ARB_SERVE_A: next_grant = GRANT_A;
			ARB_SERVE_B: next_grant = GRANT_B;
			ARB_SERVE_C: next_grant = GRANT_C;
			default:     next_grant = GRANT_NONE;
		endcase
	end

	// Outputs registered together with the state
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= ARB_IDLE;
			o_grant       <= GRANT_NONE;
			o_bus_request <= 1'b0;
		end else begin
			state         <= next_state;
			o_grant       <= next_grant;
			o_bus_request <= (next_state != ARB_IDLE); // Drops on the ready edge
		end
	end

endmodule

// ==== hw/request_mux.sv ====
//######################################
// Port to bus steering
//######################################

`timescale 1ns/100ps

module request_mux import mem_bus_pkg::*, arb_pkg::*; (
	input  grant_e    i_grant,
	input  logic      i_bus_request,
	mem_bus_if.target    port_a,
	mem_bus_if.target    port_b,
	mem_bus_if.target    port_c,
	mem_bus_if.initiator bus
);

	mem_data_t rdata_bcast; // Shared by all ports

	// Granted port's fields onto the bus
	always_comb begin
		bus.request = i_bus_request;
		bus.rw      = 1'b0;
		bus.address = '0;
		bus.wdata   = '0;

		case (i_grant)
			GRANT_A: begin
				bus.rw      = port_a.rw;
				bus.address = port_a.address;
				bus.wdata   = port_a.wdata;
			end
			GRANT_B: begin
				bus.rw      = port_b.rw;
				bus.address = port_b.address;
				bus.wdata   = port_b.wdata;
			end
			GRANT_C: begin
				bus.rw      = port_c.rw;
				bus.address = port_c.address;
				bus.wdata   = port_c.wdata;
			end
			default: begin
				// Nothing granted, bus stays zero
				bus.rw      = 1'b0;
				bus.address = '0;
				bus.wdata   = '0;
			end
		endcase
	end

	// Ready only reaches the owner
	assign port_a.ready = bus.ready && (i_grant == GRANT_A);
	assign port_b.ready = bus.ready && (i_grant == GRANT_B);
	assign port_c.ready = bus.ready && (i_grant == GRANT_C);

	// Read data is broadcast, meaningful only with that port's ready
	assign rdata_bcast  = bus.rdata;
	assign port_a.rdata = rdata_bcast;
	assign port_b.rdata = rdata_bcast;
	assign port_c.rdata = rdata_bcast;

endmodule

// ==== hw/wait_state_ram.sv ====
//######################################
// RAM target with wait states
//######################################

`timescale 1ns/100ps

`include "mem_subsys_config.svh"

module wait_state_ram import mem_bus_pkg::*; (
	input  logic      i_clock,
	input  logic      i_rst_n,
	mem_bus_if.target bus
);

	localparam int CNT_W = $clog2(`MEM_WAIT + 2);
	localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(`MEM_WAIT);
	localparam int IDX_W = $bits(mem_index_t);

	mem_data_t        mem [`MEM_WORDS];
	mem_index_t       index;
	logic [CNT_W-1:0] wait_count;
	logic             ready_q;
	mem_data_t        rdata_q;
	logic             access; // Wait states done, answer now

	// Upper address bits ignored, so addresses alias
	assign index = bus.address[IDX_W+1:2];

	assign access = bus.request && !ready_q && (wait_count == WAIT_CNT);

	// Wait counter and ready pulse
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wait_count <= '0;
			ready_q    <= 1'b0;
		end else if (ready_q) begin
			wait_count <= '0; // Clears on ready
			ready_q    <= 1'b0;
		end else if (access) begin
			ready_q <= 1'b1;
		end else if (bus.request) begin
			wait_count <= wait_count + CNT_W'(1);
		end
	end

	// Storage
	always_ff @(posedge i_clock) begin
		if (access && bus.rw) begin
			mem[index] <= bus.wdata;
		end
	end

	// Read word lines up with the ready pulse
	always_ff @(posedge i_clock) begin
		if (access && !bus.rw) begin
			rdata_q <= mem[index];
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

// ==== hw/shared_mem_top.sv ====
//######################################
// Shared memory subsystem
//######################################

`timescale 1ns/100ps

`include "mem_subsys_config.svh"

module shared_mem_top import mem_bus_pkg::*, arb_pkg::*; (
	input  logic      i_clock,
	input  logic      i_rst_n,

	// Port A, highest priority
	input  logic      i_pa_rw,
	input  logic      i_pa_request,
	input  mem_addr_t i_pa_address,
	input  mem_data_t i_pa_wdata,
	output logic      o_pa_ready,
	output mem_data_t o_pa_rdata,

	// Port B
	input  logic      i_pb_rw,
	input  logic      i_pb_request,
	input  mem_addr_t i_pb_address,
	input  mem_data_t i_pb_wdata,
	output logic      o_pb_ready,
	output mem_data_t o_pb_rdata,

	// Port C, lowest priority
	input  logic      i_pc_rw,
	input  logic      i_pc_request,
	input  mem_addr_t i_pc_address,
	input  mem_data_t i_pc_wdata,
	output logic      o_pc_ready,
	output mem_data_t o_pc_rdata
);

	mem_bus_if port_a ();
	mem_bus_if port_b ();
	mem_bus_if port_c ();
	mem_bus_if bus ();

	logic [2:0] port_request;
	grant_e     grant;
	logic       bus_request;

	// Plain ports onto the port interfaces
	assign port_a.request = i_pa_request;
	assign port_a.rw      = i_pa_rw;
	assign port_a.address = i_pa_address;
	assign port_a.wdata   = i_pa_wdata;
	assign o_pa_ready     = port_a.ready;
	assign o_pa_rdata     = port_a.rdata;

	assign port_b.request = i_pb_request;
	assign port_b.rw      = i_pb_rw;
	assign port_b.address = i_pb_address;
	assign port_b.wdata   = i_pb_wdata;
	assign o_pb_ready     = port_b.ready;
	assign o_pb_rdata     = port_b.rdata;

	assign port_c.request = i_pc_request;
	assign port_c.rw      = i_pc_rw;
	assign port_c.address = i_pc_address;
	assign port_c.wdata   = i_pc_wdata;
	assign o_pc_ready     = port_c.ready;
	assign o_pc_rdata     = port_c.rdata;

	assign port_request = {port_c.request, port_b.request, port_a.request}; // A in bit 0

	port_arbiter port_arbiter_inst (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_port_request (port_request),
		.i_bus_ready    (bus.ready),
		.o_grant        (grant),
		.o_bus_request  (bus_request)
	);

	request_mux request_mux_inst (
		.i_grant       (grant),
		.i_bus_request (bus_request),
		.port_a        (port_a.target),
		.port_b        (port_b.target),
		.port_c        (port_c.target),
		.bus           (bus.initiator)
	);

	wait_state_ram wait_state_ram_inst (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.bus     (bus.target)
	);

endmodule

// ==== verif/clock_gen.sv ====
//######################################
// Testbench clock and reset
//######################################

`timescale 1ns/100ps

module clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Release 1 ns after an edge, in step with the stimulus
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1 o_rst_n = 1'b1;
	end

endmodule

// ==== verif/shared_mem_tb.sv ====
//######################################
// Shared memory testbench
//######################################

`timescale 1ns/100ps

`include "mem_subsys_config.svh"

module shared_mem_tb import mem_bus_pkg::*; ();

	localparam int N_PORTS        = 3;
	localparam int N_SINGLE       = 20;
	localparam int N_POOL         = 16; // Words touched by random traffic
	localparam int N_RANDOM       = 250;
	localparam int TIMEOUT_CYCLES = 4000;

	logic       clock;
	logic       rst_n;
	logic       req [N_PORTS];
	logic       rw [N_PORTS];
	mem_addr_t  addr [N_PORTS];
	mem_data_t  wdata [N_PORTS];
	logic [2:0] ready; // A in bit 0
	mem_data_t  rdata [N_PORTS];

	mem_data_t  ref_mem [mem_index_t]; // Last value written per word
	int         done_order [$];        // Ports in completion order
	int         error_count = 0;
	int         cycle_count = 0;
	integer     seed;

	// Random traffic, generated before the ports start
	int         tr_port [N_RANDOM];
	logic       tr_write [N_RANDOM];
	mem_addr_t  tr_addr [N_RANDOM];
	mem_data_t  tr_data [N_RANDOM];
	int         tr_gap [N_RANDOM];

	clock_gen clock_gen_inst (
		.o_clock (clock),
		.o_rst_n (rst_n)
	);

	shared_mem_top shared_mem_top_inst (
		.i_clock      (clock),
		.i_rst_n      (rst_n),
		.i_pa_rw      (rw[0]),
		.i_pa_request (req[0]),
		.i_pa_address (addr[0]),
		.i_pa_wdata   (wdata[0]),
		.o_pa_ready   (ready[0]),
		.o_pa_rdata   (rdata[0]),
		.i_pb_rw      (rw[1]),
		.i_pb_request (req[1]),
		.i_pb_address (addr[1]),
		.i_pb_wdata   (wdata[1]),
		.o_pb_ready   (ready[1]),
		.o_pb_rdata   (rdata[1]),
		.i_pc_rw      (rw[2]),
		.i_pc_request (req[2]),
		.i_pc_address (addr[2]),
		.i_pc_wdata   (wdata[2]),
		.o_pc_ready   (ready[2]),
		.o_pc_rdata   (rdata[2])
	);

	// Word index, byte address over four, aliased by the RAM depth
	function automatic mem_index_t word_index(input mem_addr_t a);
		return mem_index_t'((a >> 2) % `MEM_WORDS);
	endfunction

	// Reference model
	function automatic mem_data_t expected_read(input mem_index_t idx);
		return ref_mem[idx];
	endfunction

	function automatic string port_name(input int p);
		case (p)
			0:       return "pa";
			1:       return "pb";
			default: return "pc";
		endcase
	endfunction

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	task automatic abort_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	// One transaction, entered 1 ns after an edge and left the same way
	// cycles counts every edge up to the ready edge, the first one samples the request
	task automatic port_access(input int p, input logic is_write, input mem_addr_t a,
			input mem_data_t d, output int cycles);
		cycles   = 0;
		req[p]   = 1'b1;
		rw[p]    = is_write;
		addr[p]  = a;
		wdata[p] = d;
		do begin
			@(posedge clock);
			cycles++;
		end while (!ready[p]);
		#1;
		req[p]   = 1'b0;
		rw[p]    = 1'b0;
		addr[p]  = '0;
		wdata[p] = '0;
	endtask

	task automatic run_port_traffic(input int p);
		int cycles;
		for (int i = 0; i < N_RANDOM; i++) begin
			if (tr_port[i] == p) begin
				if (tr_gap[i] > 0) begin
					idle_cycles(tr_gap[i]);
				end
				port_access(p, tr_write[i], tr_addr[i], tr_data[i], cycles);
			end
		end
	endtask

	// Checks every ready, reference updates on write completion
	always @(posedge clock) begin : compare_responses
		int         p;
		mem_index_t idx;
		if (!rst_n) begin
			assert (ready == 3'b000) else
				abort_run($sformatf("Error: ready = 0x%h in reset, expected 0x0", ready));
		end else if (ready != 3'b000) begin
			assert ($countones(ready) == 1) else
				abort_run($sformatf("Error: ready = 0x%h, expected one-hot", ready));
			p   = ready[0] ? 0 : (ready[1] ? 1 : 2);
			idx = word_index(addr[p]);
			assert (req[p]) else
				abort_run($sformatf("Port %s saw ready while its request was low", port_name(p)));
			if (rw[p]) begin
				ref_mem[idx] = wdata[p];
			end else begin
				assert (ref_mem.exists(idx)) else
					abort_run("A read returned from a word that was never written");
				assert (rdata[p] == expected_read(idx)) else
					abort_run($sformatf("Error: o_%s_rdata = 0x%08h, expected 0x%08h",
						port_name(p), rdata[p], expected_read(idx)));
			end
			done_order.push_back(p);
		end
	end

	always @(posedge clock) begin : count_cycles
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout after %0d cycles, a request never completed",
				cycle_count));
		end
	end

	initial begin : main_sequence
		int          cycles;
		int          wait_cycles [N_PORTS];
		logic [31:0] rnd;
		mem_addr_t   single_addr [N_SINGLE];

		seed = 59315;
		for (int p = 0; p < N_PORTS; p++) begin
			req[p]   = 1'b0;
			rw[p]    = 1'b0;
			addr[p]  = '0;
			wdata[p] = '0;
		end

		// Reset, then two quiet cycles
		do begin
			@(posedge clock);
		end while (!rst_n);
		repeat (2) begin
			@(posedge clock);
			assert (ready == 3'b000) else
				abort_run($sformatf("Error: ready = 0x%h after reset, expected 0x0", ready));
		end
		#1;

		// Port A alone, write then read back
		for (int i = 0; i < N_SINGLE; i++) begin
			rnd            = next_random();
			single_addr[i] = {rnd[31:2], 2'b00};
			port_access(0, 1'b1, single_addr[i], next_random(), cycles);
		end
		for (int i = 0; i < N_SINGLE; i++) begin
			port_access(0, 1'b0, single_addr[i], '0, cycles);
		end

		// Isolated latency on port B, counted from the sampling edge
		idle_cycles(3);
		port_access(1, 1'b1, 32'h0000_0040, 32'hCAFE_0001, cycles);
		assert (cycles - 1 == `MEM_WAIT + 2) else
			abort_run($sformatf("Error: o_pb_ready latency = 0x%0h, expected 0x%0h",
				cycles - 1, `MEM_WAIT + 2));
		idle_cycles(3);
		port_access(1, 1'b0, 32'h0000_0040, '0, cycles);
		assert (cycles - 1 == `MEM_WAIT + 2) else
			abort_run($sformatf("Error: o_pb_ready latency = 0x%0h, expected 0x%0h",
				cycles - 1, `MEM_WAIT + 2));

		// All three in the same cycle, C reads what B wrote last
		idle_cycles(2);
		done_order.delete();
		fork
			port_access(0, 1'b1, 32'h0000_0080, 32'hAAAA_0000, wait_cycles[0]);
			port_access(1, 1'b1, 32'h0000_0080, 32'hBBBB_0000, wait_cycles[1]);
			port_access(2, 1'b0, 32'h0000_0080, '0, wait_cycles[2]);
		join
		assert (done_order.size() == 3 && done_order[0] == 0 && done_order[1] == 1
				&& done_order[2] == 2) else
			abort_run("Readies did not arrive once each in the order A, B, C");
		// A wins an idle bus, so it sees the isolated latency
		assert (wait_cycles[0] - 1 == `MEM_WAIT + 2) else
			abort_run($sformatf("Error: o_pa_ready latency = 0x%0h, expected 0x%0h",
				wait_cycles[0] - 1, `MEM_WAIT + 2));

		// Fill the pool so every random read has a known value
		for (int w = 0; w < N_POOL; w++) begin
			port_access(2, 1'b1, mem_addr_t'(w * 4), next_random(), cycles);
		end

		for (int i = 0; i < N_RANDOM; i++) begin
			rnd         = next_random();
			tr_port[i]  = int'(rnd % 3);
			tr_write[i] = rnd[4];
			tr_gap[i]   = int'(rnd[9:8]);
			rnd         = next_random();
			tr_addr[i]  = {rnd[31:10], 4'b0000, rnd[5:2], 2'b00}; // Upper bits alias
			tr_data[i]  = next_random();
		end
		fork
			run_port_traffic(0);
			run_port_traffic(1);
			run_port_traffic(2);
		join
		idle_cycles(2);

		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hw
hw/mem_bus_pkg.sv
hw/arb_pkg.sv
hw/mem_bus_if.sv
hw/port_arbiter.sv
hw/request_mux.sv
hw/wait_state_ram.sv
hw/shared_mem_top.sv
verif/clock_gen.sv
verif/shared_mem_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := shared_mem_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
VFLAGS     := --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
